/* frt_link_settings.svh */
// FRT link index constants: RAM geometry, table base addresses and entry layout
`ifndef FRT_LINK_SETTINGS_SVH
`define FRT_LINK_SETTINGS_SVH

`define FRT_ADDR_SZ          10       // RAM word address width
`define FRT_WORD_SZ          16       // RAM data width
`define FRT_IP_SZ            32       // IPv4 address
`define FRT_CNT_SZ           16       // Link and net-entry counts

`define FRT_LINK_CNT_ADDR    'h010    // Number of link objects
`define FRT_LOCAL_BASE       'h040    // First local link entry
`define FRT_NET_BASE         'h200    // Net sub-entry area

`define FRT_ENTRY_WORDS      8        // Local entry stride
`define FRT_NET_ENTRY_WORDS  4        // Net sub-entry stride

// Word positions inside a local entry
`define FRT_ENT_IP_H         0
`define FRT_ENT_IP_L         1
`define FRT_ENT_TYPE         2
`define FRT_ENT_LEN          3
`define FRT_ENT_DOFF         4
`define FRT_ENT_SAVE         5
`define FRT_ENT_NET_NUM      6
`define FRT_ENT_NET_OFF      7

// Word positions inside a net sub-entry, last word unused
`define FRT_NET_LEN          0
`define FRT_NET_DOFF         1
`define FRT_NET_SAVE         2

`endif

/* frt_link_pkg.sv */
// FRT link index package: width types and the engine state encoding
`include "frt_link_settings.svh"

package frt_link_pkg;

	typedef logic [`FRT_ADDR_SZ-1:0] addr_t;   // RAM word address
	typedef logic [`FRT_WORD_SZ-1:0] word_t;   // One RAM word
	typedef logic [`FRT_IP_SZ-1:0]   ip_t;     // IPv4 address
	typedef logic [`FRT_CNT_SZ-1:0]  count_t;  // Link or net-entry count

	// Search walks RD_COUNT..COMPARE per entry, serve loops through NET_WAIT
	typedef enum logic [4:0] {
		IDLE,           // Waiting for a local request
		RD_COUNT,       // Link count on read data
		RD_IP_H,        // Entry IP high word
		RD_IP_L,        // Entry IP low word
		COMPARE,        // Match decision
		RD_TYPE,        // Device type
		RD_LEN,         // Local data length
		RD_OFFSET,      // Local data offset
		RD_SAVE,        // Local save offset
		RD_NET_NUM,     // Net sub-entry count
		RD_NET_OFFSET,  // Net sub-entry start
		NET_WAIT,       // Local result held, waiting for net request
		RD_NET_LEN,     // Net data length
		RD_NET_DOFF,    // Net data offset
		RD_NET_SAVE,    // Net save offset
		NET_DONE,       // All sub-entries served
		ERROR           // No matching link
	} index_state_e;

endpackage

/* emib_ram.sv */
// Configuration RAM: simple dual port, host write side and registered engine read side
`timescale 1ns/1ps
`include "frt_link_settings.svh"

module emib_ram
	import frt_link_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_wr_en,     // Host write strobe
	input  addr_t i_wr_addr,
	input  word_t i_wr_data,
	input  logic  i_rd_en,     // Engine read strobe
	input  addr_t i_rd_addr,
	output word_t o_rd_data    // Valid one cycle after i_rd_en
);

	localparam int DEPTH = 2 ** `FRT_ADDR_SZ;  // Full address space

	word_t mem [0:DEPTH-1];  // Config image

	always_ff @(posedge i_clk)
	begin
		if (i_wr_en)
		begin
			mem[i_wr_addr] <= i_wr_data;  // Host fill
		end
	end

	// Read returns old data on a same-address write
	always_ff @(posedge i_clk)
	begin
		if (i_rd_en)
		begin
			o_rd_data <= mem[i_rd_addr];  // Held while idle
		end
	end

endmodule

/* frt_index_fsm.sv */
// Link index FSM: walks the local link table, then serves net sub-entries on request
`timescale 1ns/1ps
`include "frt_link_settings.svh"

module frt_index_fsm
	import frt_link_pkg::*;
(
	input  logic         i_clk,
	input  logic         i_rst_n,
	input  logic         i_config_valid,     // Table loaded
	input  logic         i_index_req_local,  // Start search
	input  logic         i_index_req_net,    // Fetch next sub-entry
	input  logic         i_ip_match,         // Entry IP equals target
	input  count_t       i_link_cnt,         // Captured in RD_COUNT
	input  count_t       i_net_num,          // Captured in RD_NET_NUM
	input  word_t        i_net_offset,       // Captured in RD_NET_OFFSET, in words
	output index_state_e o_state,
	output logic         o_rd_en,
	output addr_t        o_rd_addr,
	output logic         o_done_local,
	output logic         o_done_net,
	output logic         o_index_error
);

	index_state_e state;
	index_state_e next_state;

	addr_t  entry_addr;  // First word of entry under test
	count_t entry_cnt;   // Entries rejected so far
	count_t net_served;  // Sub-entries already published
	word_t  net_sum;
	addr_t  net_addr;    // First word of next sub-entry
	logic   start;
	logic   last_entry;
	logic   net_more;
	logic   done_net;

	assign start      = i_index_req_local & i_config_valid;  // Only honoured in IDLE
	assign last_entry = (entry_cnt >= (i_link_cnt - count_t'(1)));  // Count is nonzero here
	assign net_more   = (net_served < i_net_num);

	// Net base plus published offset plus stride per served entry
	assign net_sum  = word_t'(`FRT_NET_BASE) + i_net_offset
		+ word_t'(net_served * count_t'(`FRT_NET_ENTRY_WORDS));
	assign net_addr = net_sum[`FRT_ADDR_SZ-1:0];  // Wraps inside RAM

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= IDLE;
		end
		else
		begin
			state <= next_state;
		end
	end

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:          next_state = start ? RD_COUNT : IDLE;
			RD_COUNT:      next_state = RD_IP_H;
			RD_IP_H:       next_state = (i_link_cnt == '0) ? ERROR : RD_IP_L;  // Empty table
			RD_IP_L:       next_state = COMPARE;
			COMPARE:
			begin
				if (i_ip_match)
				begin
					next_state = RD_TYPE;
				end
				else if (last_entry)
				begin
					next_state = ERROR;  // Table exhausted
				end
				else
				begin
					next_state = RD_COUNT;  // Next entry, count word reread as setup cycle
				end
			end
			RD_TYPE:       next_state = RD_LEN;
			RD_LEN:        next_state = RD_OFFSET;
			RD_OFFSET:     next_state = RD_SAVE;
			RD_SAVE:       next_state = RD_NET_NUM;
			RD_NET_NUM:    next_state = RD_NET_OFFSET;
			RD_NET_OFFSET: next_state = NET_WAIT;
			NET_WAIT:
			begin
				if (!net_more)
				begin
					next_state = NET_DONE;
				end
				else if (i_index_req_net)
				begin
					next_state = RD_NET_LEN;
				end
			end
			RD_NET_LEN:    next_state = RD_NET_DOFF;
			RD_NET_DOFF:   next_state = RD_NET_SAVE;
			RD_NET_SAVE:   next_state = NET_WAIT;
			NET_DONE:      next_state = IDLE;
			ERROR:         next_state = IDLE;
			default:       next_state = IDLE;
		endcase
	end

	// Each state addresses the word that the following state captures
	always_comb
	begin
		o_rd_en   = 1'b0;
		o_rd_addr = entry_addr;
		case (state)
			IDLE:
			begin
				o_rd_en   = start;
				o_rd_addr = addr_t'(`FRT_LINK_CNT_ADDR);
			end
			RD_COUNT:
			begin
				o_rd_en   = 1'b1;
				o_rd_addr = entry_addr + addr_t'(`FRT_ENT_IP_H);
			end
			RD_IP_H:
			begin
				o_rd_en   = 1'b1;
				o_rd_addr = entry_addr + addr_t'(`FRT_ENT_IP_L);
			end
			COMPARE:
			begin
				if (i_ip_match)
				begin
					o_rd_en   = 1'b1;
					o_rd_addr = entry_addr + addr_t'(`FRT_ENT_TYPE);
				end
				else
				begin
					o_rd_en   = !last_entry;
					o_rd_addr = addr_t'(`FRT_LINK_CNT_ADDR);
				end
			end
			RD_TYPE:
			begin
				o_rd_en   = 1'b1;
				o_rd_addr = entry_addr + addr_t'(`FRT_ENT_LEN);
			end
			RD_LEN:
			begin
				o_rd_en   = 1'b1;
				o_rd_addr = entry_addr + addr_t'(`FRT_ENT_DOFF);
			end
			RD_OFFSET:
			begin
				o_rd_en   = 1'b1;
				o_rd_addr = entry_addr + addr_t'(`FRT_ENT_SAVE);
			end
			RD_SAVE:
			begin
				o_rd_en   = 1'b1;
				o_rd_addr = entry_addr + addr_t'(`FRT_ENT_NET_NUM);
			end
			RD_NET_NUM:
			begin
				o_rd_en   = 1'b1;
				o_rd_addr = entry_addr + addr_t'(`FRT_ENT_NET_OFF);
			end
			NET_WAIT:
			begin
				o_rd_en   = net_more & i_index_req_net;
				o_rd_addr = net_addr + addr_t'(`FRT_NET_LEN);
			end
			RD_NET_LEN:
			begin
				o_rd_en   = 1'b1;
				o_rd_addr = net_addr + addr_t'(`FRT_NET_DOFF);
			end
			RD_NET_DOFF:
			begin
				o_rd_en   = 1'b1;
				o_rd_addr = net_addr + addr_t'(`FRT_NET_SAVE);
			end
			default:
			begin
				o_rd_en = 1'b0;  // No read in the remaining states
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			entry_addr <= addr_t'(`FRT_LOCAL_BASE);
			entry_cnt  <= '0;
			net_served <= '0;
			done_net   <= 1'b0;
		end
		else
		begin
			done_net <= (state == RD_NET_SAVE);  // Save offset lands on same edge
			case (state)
				IDLE:
				begin
					entry_addr <= addr_t'(`FRT_LOCAL_BASE);
					entry_cnt  <= '0;
					net_served <= '0;
				end
				COMPARE:
				begin
					if (!i_ip_match)
					begin
						entry_addr <= entry_addr + addr_t'(`FRT_ENTRY_WORDS);  // Step to next entry
						entry_cnt  <= entry_cnt + count_t'(1);
					end
				end
				RD_NET_SAVE: net_served <= net_served + count_t'(1);
				default: ;
			endcase
		end
	end

	assign o_state       = state;
	assign o_done_local  = state inside {NET_WAIT, RD_NET_LEN, RD_NET_DOFF, RD_NET_SAVE};
	assign o_done_net    = done_net;
	assign o_index_error = (state == ERROR);  // Single cycle, ERROR always exits

endmodule

/* frt_field_regs.sv */
// Link field registers: capture count, entry IP and published fields from RAM read data
`timescale 1ns/1ps

module frt_field_regs
	import frt_link_pkg::*;
(
	input  logic         i_clk,
	input  logic         i_rst_n,
	input  index_state_e i_state,               // Selects which field loads
	input  word_t        i_rd_data,             // RAM data for this state
	input  ip_t          i_frt_ip,              // Target IP
	output logic         o_ip_match,
	output count_t       o_link_cnt,
	output word_t        o_link_device_type,
	output word_t        o_offset_len_local,
	output word_t        o_data_offset_local,
	output word_t        o_save_offset_local,
	output count_t       o_linkobj_net_num,
	output word_t        o_linkobj_net_offset,
	output word_t        o_offset_len_net,
	output word_t        o_data_offset_net,
	output word_t        o_save_offset_net
);

	ip_t entry_ip;  // IP of entry under test

	// Table stores byte values, engine publishes word values
	function automatic word_t to_words(input word_t bytes);
		return word_t'(bytes >> 1);
	endfunction

	assign o_ip_match = (entry_ip == i_frt_ip);  // Valid in COMPARE

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			entry_ip             <= '0;
			o_link_cnt           <= '0;
			o_link_device_type   <= '0;
			o_offset_len_local   <= '0;
			o_data_offset_local  <= '0;
			o_save_offset_local  <= '0;
			o_linkobj_net_num    <= '0;
			o_linkobj_net_offset <= '0;
			o_offset_len_net     <= '0;
			o_data_offset_net    <= '0;
			o_save_offset_net    <= '0;
		end
		else
		begin
			case (i_state)
				RD_COUNT:      o_link_cnt <= count_t'(i_rd_data);
				RD_IP_H:       entry_ip[31:16] <= i_rd_data;
				RD_IP_L:       entry_ip[15:0] <= i_rd_data;
				RD_TYPE:       o_link_device_type <= i_rd_data;  // Unshifted
				RD_LEN:        o_offset_len_local <= to_words(i_rd_data);
				RD_OFFSET:     o_data_offset_local <= to_words(i_rd_data);
				RD_SAVE:       o_save_offset_local <= to_words(i_rd_data);
				RD_NET_NUM:    o_linkobj_net_num <= count_t'(i_rd_data);  // Unshifted
				RD_NET_OFFSET: o_linkobj_net_offset <= to_words(i_rd_data);
				RD_NET_LEN:    o_offset_len_net <= to_words(i_rd_data);
				RD_NET_DOFF:   o_data_offset_net <= to_words(i_rd_data);
				RD_NET_SAVE:   o_save_offset_net <= to_words(i_rd_data);
				default: ;     // Fields hold, error leaves old results
			endcase
		end
	end

endmodule

/* frt_link_index.sv */
// FRT link index top: configuration RAM, index FSM and field registers
`timescale 1ns/1ps

module frt_link_index
	import frt_link_pkg::*;
(
	input  logic   i_clk,
	input  logic   i_rst_n,
	input  logic   i_ram_wr_en,           // Host write, idle only
	input  addr_t  i_ram_wr_addr,
	input  word_t  i_ram_wr_data,
	input  logic   i_config_valid,
	input  ip_t    i_frt_ip,
	input  logic   i_index_req_local,
	input  logic   i_index_req_net,
	output word_t  o_link_device_type,
	output word_t  o_offset_len_local,
	output word_t  o_data_offset_local,
	output word_t  o_save_offset_local,
	output count_t o_linkobj_net_num,
	output word_t  o_linkobj_net_offset,
	output word_t  o_offset_len_net,
	output word_t  o_data_offset_net,
	output word_t  o_save_offset_net,
	output logic   o_done_local,
	output logic   o_done_net,
	output logic   o_index_error
);

	index_state_e state;
	logic         rd_en;
	addr_t        rd_addr;
	word_t        rd_data;
	logic         ip_match;
	count_t       link_cnt;

	emib_ram u_ram (
		.i_clk     (i_clk),
		.i_wr_en   (i_ram_wr_en),
		.i_wr_addr (i_ram_wr_addr),
		.i_wr_data (i_ram_wr_data),
		.i_rd_en   (rd_en),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data)
	);

	frt_index_fsm u_fsm (
		.i_clk             (i_clk),
		.i_rst_n           (i_rst_n),
		.i_config_valid    (i_config_valid),
		.i_index_req_local (i_index_req_local),
		.i_index_req_net   (i_index_req_net),
		.i_ip_match        (ip_match),
		.i_link_cnt        (link_cnt),
		.i_net_num         (o_linkobj_net_num),     // Published count drives serve loop
		.i_net_offset      (o_linkobj_net_offset),  // Already in words
		.o_state           (state),
		.o_rd_en           (rd_en),
		.o_rd_addr         (rd_addr),
		.o_done_local      (o_done_local),
		.o_done_net        (o_done_net),
		.o_index_error     (o_index_error)
	);

	frt_field_regs u_fields (
		.i_clk                (i_clk),
		.i_rst_n              (i_rst_n),
		.i_state              (state),
		.i_rd_data            (rd_data),
		.i_frt_ip             (i_frt_ip),
		.o_ip_match           (ip_match),
		.o_link_cnt           (link_cnt),
		.o_link_device_type   (o_link_device_type),
		.o_offset_len_local   (o_offset_len_local),
		.o_data_offset_local  (o_data_offset_local),
		.o_save_offset_local  (o_save_offset_local),
		.o_linkobj_net_num    (o_linkobj_net_num),
		.o_linkobj_net_offset (o_linkobj_net_offset),
		.o_offset_len_net     (o_offset_len_net),
		.o_data_offset_net    (o_data_offset_net),
		.o_save_offset_net    (o_save_offset_net)
	);

endmodule

/* tb_frt_model.svh */
// Testbench reference model for the FRT link index: config image and table layout lookups
`ifndef TB_FRT_MODEL_SVH
`define TB_FRT_MODEL_SVH

localparam int IMG_WORDS = 2 ** `FRT_ADDR_SZ;  // Whole RAM is mirrored

word_t  img [0:IMG_WORDS-1];  // Expected RAM contents
integer seed = 56;            // Fixed seed for all stimulus

function automatic logic [31:0] rand32();
	return $random(seed);
endfunction

function automatic word_t entry_word(input int i, input int w);
	return img[addr_t'(`FRT_LOCAL_BASE + `FRT_ENTRY_WORDS * i + w)];  // Local entry i, word w
endfunction

function automatic void set_entry_word(input int i, input int w, input word_t val);
	img[addr_t'(`FRT_LOCAL_BASE + `FRT_ENTRY_WORDS * i + w)] = val;
endfunction

function automatic ip_t entry_ip(input int i);
	return {entry_word(i, `FRT_ENT_IP_H), entry_word(i, `FRT_ENT_IP_L)};
endfunction

// Sub-entry k of link i, the stored net offset is in bytes
function automatic word_t net_word(input int i, input int k, input int w);
	int off;
	off = int'(entry_word(i, `FRT_ENT_NET_OFF) >> 1);
	return img[addr_t'(`FRT_NET_BASE + off + `FRT_NET_ENTRY_WORDS * k + w)];
endfunction

// Index of the first link whose IP equals the target, -1 when none
function automatic int find_link(input ip_t target);
	int n;
	n = int'(img[addr_t'(`FRT_LINK_CNT_ADDR)]);
	for (int i = 0; i < n; i++)
	begin
		if (entry_ip(i) == target)
			return i;
	end
	return -1;
endfunction

// Random image, then a table of n_links entries laid over it
task automatic build_table(input int n_links);
	logic [31:0] r;
	for (int a = 0; a < IMG_WORDS; a++)
	begin
		r = rand32();
		img[addr_t'(a)] = r[15:0];  // Lengths, offsets, types stay random
	end
	img[addr_t'(`FRT_LINK_CNT_ADDR)] = word_t'(n_links);
	for (int i = 0; i < n_links; i++)
	begin
		r = rand32();
		set_entry_word(i, `FRT_ENT_IP_H, r[31:16]);
		set_entry_word(i, `FRT_ENT_IP_L, {r[15:8], 8'(i)});  // Index byte keeps IPs distinct
		r = rand32();
		set_entry_word(i, `FRT_ENT_NET_NUM, word_t'(r[2:0] % 3'd5));  // 0 to 4 sub-entries
		set_entry_word(i, `FRT_ENT_NET_OFF, word_t'(32 * i) | word_t'(r[3]));  // Odd bit dropped
	end
endtask

`endif

/* tb_frt_link_index.sv */
// Testbench for the FRT link index: random tables, local search and net serve checks
`timescale 1ns/1ps
`include "frt_link_settings.svh"

module tb_frt_link_index
	import frt_link_pkg::*;
();

	localparam int NUM_TESTS  = 16;
	localparam int MAX_CYCLES = (NUM_TESTS + 4) * (2 ** `FRT_ADDR_SZ + 200);  // Load, search, serve

	logic   i_clk = 1'b0;
	logic   i_rst_n;
	logic   i_ram_wr_en;
	addr_t  i_ram_wr_addr;
	word_t  i_ram_wr_data;
	logic   i_config_valid;
	ip_t    i_frt_ip;
	logic   i_index_req_local;
	logic   i_index_req_net;
	word_t  o_link_device_type;
	word_t  o_offset_len_local;
	word_t  o_data_offset_local;
	word_t  o_save_offset_local;
	count_t o_linkobj_net_num;
	word_t  o_linkobj_net_offset;
	word_t  o_offset_len_net;
	word_t  o_data_offset_net;
	word_t  o_save_offset_net;
	logic   o_done_local;
	logic   o_done_net;
	logic   o_index_error;
	int     cycle_cnt = 0;
	word_t  last_type;  // Device type of the last hit, kept through a miss

	`include "tb_frt_model.svh"

	frt_link_index UUT (
		.i_clk                (i_clk),
		.i_rst_n              (i_rst_n),
		.i_ram_wr_en          (i_ram_wr_en),
		.i_ram_wr_addr        (i_ram_wr_addr),
		.i_ram_wr_data        (i_ram_wr_data),
		.i_config_valid       (i_config_valid),
		.i_frt_ip             (i_frt_ip),
		.i_index_req_local    (i_index_req_local),
		.i_index_req_net      (i_index_req_net),
		.o_link_device_type   (o_link_device_type),
		.o_offset_len_local   (o_offset_len_local),
		.o_data_offset_local  (o_data_offset_local),
		.o_save_offset_local  (o_save_offset_local),
		.o_linkobj_net_num    (o_linkobj_net_num),
		.o_linkobj_net_offset (o_linkobj_net_offset),
		.o_offset_len_net     (o_offset_len_net),
		.o_data_offset_net    (o_data_offset_net),
		.o_save_offset_net    (o_save_offset_net),
		.o_done_local         (o_done_local),
		.o_done_net           (o_done_net),
		.o_index_error        (o_index_error)
	);

	always #50 i_clk = ~i_clk;  // 100 ns period

	always @(posedge i_clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
		begin
			$display("Timeout: the DUT stopped responding after %0d cycles", cycle_cnt);
			$display("TEST FAILED");
			$fatal(1, "Run ended by the cycle limit");
		end
	end

	task automatic check_value(input string what, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	// Host writes the whole image, engine idle and config marked invalid meanwhile
	task automatic load_image();
		@(posedge i_clk);
		i_config_valid <= 1'b0;
		for (int a = 0; a < IMG_WORDS; a++)
		begin
			i_ram_wr_en   <= 1'b1;
			i_ram_wr_addr <= addr_t'(a);
			i_ram_wr_data <= img[addr_t'(a)];
			@(posedge i_clk);
		end
		i_ram_wr_en    <= 1'b0;
		i_config_valid <= 1'b1;
	endtask

	// Request with config invalid must leave the engine idle
	task automatic ignored_request(input ip_t target);
		@(posedge i_clk);
		i_config_valid    <= 1'b0;
		i_frt_ip          <= target;
		i_index_req_local <= 1'b1;
		@(posedge i_clk);
		i_index_req_local <= 1'b0;
		repeat (20)
		begin
			@(negedge i_clk);
			check_value("flags after ignored request",
				word_t'({o_done_local, o_done_net, o_index_error}), '0);
		end
		@(posedge i_clk);
		i_config_valid <= 1'b1;
	endtask

	// One net request, pulsed or held for a second cycle
	task automatic serve_net(input int idx, input int k);
		logic [31:0] r;
		r = rand32();
		repeat (int'(r[1:0])) @(posedge i_clk);  // Random gap before the request
		@(posedge i_clk);
		i_index_req_net <= 1'b1;
		@(posedge i_clk);
		if (r[2])
			@(posedge i_clk);
		i_index_req_net <= 1'b0;
		@(negedge i_clk);
		while (!o_done_net)
		begin
			check_value("done_local in net phase", word_t'(o_done_local), 16'h1);
			@(negedge i_clk);
		end
		check_value($sformatf("net %0d length", k), o_offset_len_net,
			net_word(idx, k, `FRT_NET_LEN) >> 1);
		check_value($sformatf("net %0d data offset", k), o_data_offset_net,
			net_word(idx, k, `FRT_NET_DOFF) >> 1);
		check_value($sformatf("net %0d save offset", k), o_save_offset_net,
			net_word(idx, k, `FRT_NET_SAVE) >> 1);
	endtask

	// Search for target, then serve every sub-entry or check the error pulse
	task automatic run_search(input ip_t target);
		int    idx;
		idx = find_link(target);
		@(posedge i_clk);
		i_frt_ip          <= target;
		i_index_req_local <= 1'b1;
		@(posedge i_clk);
		i_index_req_local <= 1'b0;
		@(negedge i_clk);
		while (!o_done_local && !o_index_error && !o_done_net)
			@(negedge i_clk);
		check_value("done_net during search", word_t'(o_done_net), '0);
		if (idx < 0)
		begin
			check_value("index error", word_t'(o_index_error), 16'h1);
			check_value("done_local on miss", word_t'(o_done_local), '0);
			check_value("device type kept on miss", o_link_device_type, last_type);
			@(negedge i_clk);
			check_value("index error width", word_t'(o_index_error), '0);
		end
		else
		begin
			check_value("index error on hit", word_t'(o_index_error), '0);
			check_value("device type", o_link_device_type, entry_word(idx, `FRT_ENT_TYPE));
			check_value("local length", o_offset_len_local, entry_word(idx, `FRT_ENT_LEN) >> 1);
			check_value("local data offset", o_data_offset_local,
				entry_word(idx, `FRT_ENT_DOFF) >> 1);
			check_value("local save offset", o_save_offset_local,
				entry_word(idx, `FRT_ENT_SAVE) >> 1);
			check_value("net count", o_linkobj_net_num, entry_word(idx, `FRT_ENT_NET_NUM));
			check_value("net offset", o_linkobj_net_offset,
				entry_word(idx, `FRT_ENT_NET_OFF) >> 1);
			last_type = entry_word(idx, `FRT_ENT_TYPE);
			for (int k = 0; k < int'(entry_word(idx, `FRT_ENT_NET_NUM)); k++)
				serve_net(idx, k);
			@(negedge i_clk);
			check_value("done_local after net phase", word_t'(o_done_local), '0);
		end
	endtask

	initial
	begin
		logic [31:0] r;
		int          n;
		last_type          = '0;  // Reset value of the published type
		i_rst_n           <= 1'b0;
		i_ram_wr_en       <= 1'b0;
		i_ram_wr_addr     <= '0;
		i_ram_wr_data     <= '0;
		i_config_valid    <= 1'b0;
		i_frt_ip          <= '0;
		i_index_req_local <= 1'b0;
		i_index_req_net   <= 1'b0;
		repeat (5) @(posedge i_clk);
		i_rst_n <= 1'b1;
		@(negedge i_clk);
		check_value("fields after reset", o_link_device_type | o_offset_len_local
			| o_data_offset_local | o_save_offset_local | o_linkobj_net_num
			| o_linkobj_net_offset | o_offset_len_net | o_data_offset_net
			| o_save_offset_net, '0);
		check_value("flags after reset", word_t'({o_done_local, o_done_net, o_index_error}), '0);

		build_table(3);
		load_image();
		ignored_request(entry_ip(0));
		run_search(entry_ip(0));  // Accepted once config is valid

		for (int t = 0; t < NUM_TESTS; t++)
		begin
			r = rand32();
			n = 1 + int'(r[7:0]) % 12;
			build_table(n);
			load_image();
			r = rand32();
			if (t % 4 == 3)
				run_search({r[31:8], 8'hFF});  // Index byte FF never in table
			else
				run_search(entry_ip(int'(r[7:0]) % n));
		end

		build_table(0);  // Empty table
		load_image();
		run_search(rand32());

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+.
frt_link_pkg.sv
emib_ram.sv
frt_index_fsm.sv
frt_field_regs.sv
frt_link_index.sv
tb_frt_link_index.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the FRT link index testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
	--top-module tb_frt_link_index -o tb_frt_link_index
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_frt_link_index > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
fi

if grep -q "^TEST PASSED$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
